// ==== verilog/vec_settings.svh ====
// Sizing macros for the vector unit
// Register count, data bytes and index widths
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Bytes in one vector register
`define VEC_DATA_BYTES 16

// Number of vector registers
`define VEC_NUM_REGS 8

// Register index width
`define VEC_REG_ADDR_W 3

// Width of vl and vstart that holds 0 to VEC_DATA_BYTES
`define VEC_LEN_W 5

`endif

// ==== verilog/vec_pkg.sv ====
// Vector unit package
// Data, byte enable, mask, index and length types
// Enums for element width, operation and sequencer state
`include "vec_settings.svh"

package vec_pkg;

    // One vector register
    typedef logic [`VEC_DATA_BYTES*8-1:0] vec_data_t;

    // One bit per data byte
    typedef logic [`VEC_DATA_BYTES-1:0] vec_byte_en_t;

    // One bit per element index as laid out in a mask register
    typedef logic [`VEC_DATA_BYTES-1:0] vec_elem_mask_t;

    typedef logic [`VEC_REG_ADDR_W-1:0] vec_reg_addr_t;

    // vl or vstart
    typedef logic [`VEC_LEN_W-1:0] vec_len_t;

    // Element width encoded as log2 of the bytes per element
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } vec_sew_e;

    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MSEQ = 2'd2,
        OP_MSLT = 2'd3
    } vec_op_e;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        EXEC,
        WRITE,
        RESP
    } vec_ctrl_state_e;

endpackage

// ==== verilog/vec_op_if.sv ====
// Decoder to lane ALU bundle
// Operands, operation fields and per-byte lane controls
interface vec_op_if import vec_pkg::*; ();

    vec_data_t      srca;
    vec_data_t      srcb;
    vec_data_t      old_vd;
    vec_byte_en_t   byte_valid;
    vec_byte_en_t   merge;
    vec_elem_mask_t elem_active;
    vec_byte_en_t   wr_byte_en;
    vec_op_e        op;
    vec_sew_e       sew;

    modport decode (
        input  op, sew,
        output byte_valid, merge, elem_active, wr_byte_en
    );

    modport alu (
        input srca, srcb, old_vd, byte_valid, merge, elem_active, wr_byte_en, op, sew
    );

endinterface

// ==== verilog/vec_elem_decode.sv ====
// Element decoder
// Byte valids, carry merge bits, active elements and write byte enables
`include "vec_settings.svh"

module vec_elem_decode
import vec_pkg::*;
(
    vec_op_if.decode       op_if,
    input  vec_len_t       vl,
    input  vec_len_t       vstart,
    input  logic           vm,
    input  vec_elem_mask_t v0_mask
);

localparam int NB         = `VEC_DATA_BYTES;
// Bytes that hold a mask result with one bit per element
localparam int MASK_BYTES = NB / 8;

logic [3:0]     sew_vec;
vec_len_t       elem_count;
logic           is_cmp;
vec_elem_mask_t active;
vec_byte_en_t   valid;
vec_byte_en_t   merge;

// One-hot element width
assign sew_vec[0] = (op_if.sew == SEW_8);
assign sew_vec[1] = (op_if.sew == SEW_16);
assign sew_vec[2] = (op_if.sew == SEW_32);
assign sew_vec[3] = (op_if.sew == SEW_64);

// Elements that fit in one register
assign elem_count = vec_len_t'(NB) >> op_if.sew;

assign is_cmp = (op_if.op == OP_MSEQ) || (op_if.op == OP_MSLT);

// Element window [vstart, vl), register capacity and v0 mask
generate
    for (genvar i = 0; i < NB; i++) begin : gen_elem
        assign active[i] = (vstart <= vec_len_t'(i)) &
                           (vl > vec_len_t'(i)) &
                           (elem_count > vec_len_t'(i)) &
                           (~vm | v0_mask[i]);
    end
endgenerate

// Per byte, valid comes from the owning element
// merge is set where the carry runs into the next byte of the same element
generate
    for (genvar b = 0; b < NB; b++) begin : gen_byte
        assign valid[b] = (sew_vec[0] & active[b]) |
                          (sew_vec[1] & active[b/2]) |
                          (sew_vec[2] & active[b/4]) |
                          (sew_vec[3] & active[b/8]);

        assign merge[b] = (sew_vec[1] & ((b % 2) != 1)) |
                          (sew_vec[2] & ((b % 4) != 3)) |
                          (sew_vec[3] & ((b % 8) != 7));
    end
endgenerate

assign op_if.elem_active = active;
assign op_if.byte_valid  = valid;
assign op_if.merge       = merge;

// Compares only touch the mask bytes while the ALU keeps inactive mask bits
assign op_if.wr_byte_en = is_cmp ? vec_byte_en_t'({MASK_BYTES{1'b1}}) : valid;

// An active element needs a known element width
always_comb begin
    if (active != '0) begin
        assert (!$isunknown(op_if.sew))
            else $error("element width unknown while elements are active");
    end
end

endmodule

// ==== verilog/vec_regfile.sv ====
// Vector register file
// Registered operand reads, combinational host read port
// Byte-enabled datapath write and full-width host load
`include "vec_settings.svh"

module vec_regfile
import vec_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           rd_en,
    input  vec_reg_addr_t  vs1_addr,
    input  vec_reg_addr_t  vs2_addr,
    input  vec_reg_addr_t  vd_addr,
    input  logic           wr_en,
    input  vec_byte_en_t   wr_byte_en,
    input  vec_data_t      wr_data,
    input  logic           load_en,
    input  vec_reg_addr_t  load_addr,
    input  vec_data_t      load_data,
    input  vec_reg_addr_t  host_addr,
    output vec_data_t      srca,
    output vec_data_t      srcb,
    output vec_data_t      old_vd,
    output vec_elem_mask_t v0_mask,
    output vec_data_t      host_data
);

vec_data_t regs [`VEC_NUM_REGS];

always_ff @(posedge clk) begin
    if (reset) begin
        for (int r = 0; r < `VEC_NUM_REGS; r++) begin
            regs[r] <= '0;
        end
    end else if (load_en) begin
        regs[load_addr] <= load_data;
    end else if (wr_en) begin
        for (int b = 0; b < `VEC_DATA_BYTES; b++) begin
            if (wr_byte_en[b]) begin
                regs[vd_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end
end

// Operands stay put until the next read so decode and ALU see stable inputs
always_ff @(posedge clk) begin
    if (rd_en) begin
        srca    <= regs[vs1_addr];
        srcb    <= regs[vs2_addr];
        old_vd  <= regs[vd_addr];
        v0_mask <= regs[0][`VEC_DATA_BYTES-1:0];
    end
end

assign host_data = regs[host_addr];

// Host loads only happen while the sequencer is idle
assert property (@(posedge clk) disable iff (reset) !(wr_en && load_en))
    else $error("datapath write collides with host load");

endmodule

// ==== verilog/vec_lane_alu.sv ====
// Byte-lane vector ALU
// Add and subtract with element-bounded carries, equal and signed-less compares
// Merged result registered on exec_en
`include "vec_settings.svh"

module vec_lane_alu
import vec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      exec_en,
    vec_op_if.alu     op_if,
    output vec_data_t result
);

localparam int NB = `VEC_DATA_BYTES;

logic           is_sub;
logic           is_cmp;
vec_data_t      lane_sum;
vec_byte_en_t   lane_cout;
vec_byte_en_t   lane_eq;
vec_byte_en_t   lane_less;
vec_byte_en_t   cmp_byte;
vec_elem_mask_t elem_cmp;
vec_elem_mask_t mask_new;
vec_data_t      arith_data;
vec_data_t      next_result;

// Compares run through the subtract path as vs2 minus vs1
assign is_sub = (op_if.op != OP_ADD);
assign is_cmp = (op_if.op == OP_MSEQ) || (op_if.op == OP_MSLT);

generate
    for (genvar b = 0; b < NB; b++) begin : gen_lane
        logic       carry_in;
        logic [7:0] opa;
        logic [7:0] opb;

        assign opa = op_if.srcb[8*b +: 8];
        assign opb = is_sub ? ~op_if.srca[8*b +: 8] : op_if.srca[8*b +: 8];

        // Carry-in is the subtract one at each element start
        if (b == 0) begin : gen_first
            assign carry_in   = is_sub;
            assign lane_eq[b] = (lane_sum[8*b +: 8] == 8'h00);
        end else begin : gen_next
            assign carry_in   = op_if.merge[b-1] ? lane_cout[b-1] : is_sub;
            assign lane_eq[b] = (lane_sum[8*b +: 8] == 8'h00) &
                                (~op_if.merge[b-1] | lane_eq[b-1]);
        end

        assign {lane_cout[b], lane_sum[8*b +: 8]} = {1'b0, opa} + {1'b0, opb} + 9'(carry_in);

        // Signed vs2 < vs1 which holds its meaning at an element's top byte
        assign lane_less[b] = (opa[7] & ~op_if.srca[8*b+7]) |
                              (~(opa[7] ^ op_if.srca[8*b+7]) & lane_sum[8*b+7]);
    end
endgenerate

// Pick each element's compare bit from its top byte
always_comb begin
    cmp_byte = (op_if.op == OP_MSEQ) ? lane_eq : lane_less;
    elem_cmp = '0;
    unique case (op_if.sew)
        SEW_8: begin
            elem_cmp = cmp_byte;
        end
        SEW_16: begin
            for (int i = 0; i < NB/2; i++) begin
                elem_cmp[i] = cmp_byte[2*i+1];
            end
        end
        SEW_32: begin
            for (int i = 0; i < NB/4; i++) begin
                elem_cmp[i] = cmp_byte[4*i+3];
            end
        end
        SEW_64: begin
            for (int i = 0; i < NB/8; i++) begin
                elem_cmp[i] = cmp_byte[8*i+7];
            end
        end
    endcase
end

// Inactive bytes and mask bits stay undisturbed
always_comb begin
    for (int b = 0; b < NB; b++) begin
        arith_data[8*b +: 8] = op_if.byte_valid[b] ? lane_sum[8*b +: 8]
                                                   : op_if.old_vd[8*b +: 8];
    end
    mask_new = (elem_cmp & op_if.elem_active) | (op_if.old_vd[NB-1:0] & ~op_if.elem_active);
    if (is_cmp) begin
        next_result = {op_if.old_vd[$bits(vec_data_t)-1:NB], mask_new};
    end else begin
        next_result = arith_data;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        result <= '0;
    end else if (exec_en) begin
        result <= next_result;
    end
end

endmodule

// ==== verilog/vec_issue_ctrl.sv ====
// Issue sequencer
// Command accept, instruction field capture and READ/EXEC/WRITE/RESP stepping
module vec_issue_ctrl
import vec_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  vec_op_e       cmd_op,
    input  vec_reg_addr_t cmd_vd,
    input  vec_reg_addr_t cmd_vs1,
    input  vec_reg_addr_t cmd_vs2,
    input  vec_sew_e      cmd_sew,
    input  vec_len_t      cmd_vl,
    input  vec_len_t      cmd_vstart,
    input  logic          cmd_vm,
    input  logic          load_valid,
    output logic          load_ready,
    output logic          resp_valid,
    input  logic          resp_ready,
    output vec_reg_addr_t vd_addr,
    output vec_reg_addr_t vs1_addr,
    output vec_reg_addr_t vs2_addr,
    output vec_op_e       op,
    output vec_sew_e      sew,
    output vec_len_t      vl,
    output vec_len_t      vstart,
    output logic          vm,
    output logic          rd_en,
    output logic          exec_en,
    output logic          wr_en
);

vec_ctrl_state_e state;
vec_ctrl_state_e state_next;
logic            cmd_fire;

assign cmd_fire = cmd_valid & cmd_ready;

always_comb begin
    state_next = state;
    unique case (state)
        IDLE:    if (cmd_fire) state_next = READ;
        READ:    state_next = EXEC;
        EXEC:    state_next = WRITE;
        WRITE:   state_next = RESP;
        RESP:    if (resp_ready) state_next = IDLE;
        default: state_next = IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        state    <= IDLE;
        op       <= OP_ADD;
        sew      <= SEW_8;
        vd_addr  <= '0;
        vs1_addr <= '0;
        vs2_addr <= '0;
        vl       <= '0;
        vstart   <= '0;
        vm       <= 1'b0;
    end else begin
        state <= state_next;
        if (cmd_fire) begin
            op       <= cmd_op;
            sew      <= cmd_sew;
            vd_addr  <= cmd_vd;
            vs1_addr <= cmd_vs1;
            vs2_addr <= cmd_vs2;
            vl       <= cmd_vl;
            vstart   <= cmd_vstart;
            vm       <= cmd_vm;
        end
    end
end

// A pending command wins over a host load
assign cmd_ready  = (state == IDLE);
assign load_ready = (state == IDLE) & ~cmd_valid;
assign resp_valid = (state == RESP);

assign rd_en   = (state == READ);
assign exec_en = (state == EXEC);
assign wr_en   = (state == WRITE);

// An accepted command starts the read with its fields held
assert property (@(posedge clk) disable iff (reset)
    cmd_fire |=> state == READ && op == $past(cmd_op) && vd_addr == $past(cmd_vd))
    else $error("accepted command not captured");

assert property (@(posedge clk) disable iff (reset) resp_valid && !resp_ready |=> resp_valid)
    else $error("resp_valid dropped before resp_ready");

// A host load never starts an instruction
assert property (@(posedge clk) disable iff (reset)
    load_valid && load_ready |=> state == IDLE)
    else $error("sequencer left IDLE on a host load");

endmodule

// ==== verilog/vec_unit_top.sv ====
// Vector execution unit top level
// Sequencer, register file, element decoder and lane ALU
module vec_unit_top
import vec_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    output logic          cmd_ready,
    input  vec_op_e       cmd_op,
    input  vec_reg_addr_t cmd_vd,
    input  vec_reg_addr_t cmd_vs1,
    input  vec_reg_addr_t cmd_vs2,
    input  vec_sew_e      cmd_sew,
    input  vec_len_t      cmd_vl,
    input  vec_len_t      cmd_vstart,
    input  logic          cmd_vm,
    input  logic          load_valid,
    output logic          load_ready,
    input  vec_reg_addr_t load_addr,
    input  vec_data_t     load_data,
    output logic          resp_valid,
    input  logic          resp_ready,
    input  vec_reg_addr_t rd_addr,
    output vec_data_t     rd_data
);

vec_reg_addr_t  vd_addr;
vec_reg_addr_t  vs1_addr;
vec_reg_addr_t  vs2_addr;
vec_len_t       vl;
vec_len_t       vstart;
logic           vm;
logic           rd_en;
logic           exec_en;
logic           wr_en;
logic           load_en;
vec_elem_mask_t v0_mask;
vec_data_t      alu_result;

vec_op_if op_if ();

assign load_en = load_valid & load_ready;

vec_issue_ctrl ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_vd     (cmd_vd),
    .cmd_vs1    (cmd_vs1),
    .cmd_vs2    (cmd_vs2),
    .cmd_sew    (cmd_sew),
    .cmd_vl     (cmd_vl),
    .cmd_vstart (cmd_vstart),
    .cmd_vm     (cmd_vm),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .vd_addr    (vd_addr),
    .vs1_addr   (vs1_addr),
    .vs2_addr   (vs2_addr),
    .op         (op_if.op),
    .sew        (op_if.sew),
    .vl         (vl),
    .vstart     (vstart),
    .vm         (vm),
    .rd_en      (rd_en),
    .exec_en    (exec_en),
    .wr_en      (wr_en)
);

vec_regfile regfile_i (
    .clk        (clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .vs1_addr   (vs1_addr),
    .vs2_addr   (vs2_addr),
    .vd_addr    (vd_addr),
    .wr_en      (wr_en),
    .wr_byte_en (op_if.wr_byte_en),
    .wr_data    (alu_result),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .host_addr  (rd_addr),
    .srca       (op_if.srca),
    .srcb       (op_if.srcb),
    .old_vd     (op_if.old_vd),
    .v0_mask    (v0_mask),
    .host_data  (rd_data)
);

vec_elem_decode decode_i (
    .op_if   (op_if.decode),
    .vl      (vl),
    .vstart  (vstart),
    .vm      (vm),
    .v0_mask (v0_mask)
);

vec_lane_alu alu_i (
    .clk     (clk),
    .reset   (reset),
    .exec_en (exec_en),
    .op_if   (op_if.alu),
    .result  (alu_result)
);

endmodule

// ==== tb/vec_unit_tb.sv ====
// Directed testbench for the vector execution unit
// Reference model of the register file, xorshift stimulus and check tasks
`include "vec_settings.svh"

module vec_unit_tb
import vec_pkg::*;
;

localparam int TIMEOUT_CYCLES = 50;

logic          clk;
logic          reset;
logic          cmd_valid;
logic          cmd_ready;
vec_op_e       cmd_op;
vec_reg_addr_t cmd_vd;
vec_reg_addr_t cmd_vs1;
vec_reg_addr_t cmd_vs2;
vec_sew_e      cmd_sew;
vec_len_t      cmd_vl;
vec_len_t      cmd_vstart;
logic          cmd_vm;
logic          load_valid;
logic          load_ready;
vec_reg_addr_t load_addr;
vec_data_t     load_data;
logic          resp_valid;
logic          resp_ready;
vec_reg_addr_t rd_addr;
vec_data_t     rd_data;

vec_data_t   model_regs [`VEC_NUM_REGS];
logic [31:0] rng_state;
int          num_checks;
int          num_errors;

vec_unit_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_vd     (cmd_vd),
    .cmd_vs1    (cmd_vs1),
    .cmd_vs2    (cmd_vs2),
    .cmd_sew    (cmd_sew),
    .cmd_vl     (cmd_vl),
    .cmd_vstart (cmd_vstart),
    .cmd_vm     (cmd_vm),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
);

always #50 clk = ~clk;

function automatic logic [31:0] xorshift_step(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] rand_word();
    rng_state = xorshift_step(rng_state);
    return rng_state;
endfunction

function automatic vec_data_t rand_vec();
    return {rand_word(), rand_word(), rand_word(), rand_word()};
endfunction

// Inputs change a fixed delay after the rising edge
task automatic next_drive_slot();
    @(posedge clk);
    #10;
endtask

task automatic abort_on_timeout(input string what);
    $display("ERROR: timed out waiting for %s at time %0t", what, $time);
    $display("Simulation failed");
    $finish;
endtask

// An element is active in [vstart, vl) below the element count and with its v0 bit when masked
task automatic predict_cmd(input vec_op_e op, input int vd, input int vs1, input int vs2,
                           input vec_sew_e sew, input int vl, input int vstart,
                           input logic vm);
    vec_data_t   a;
    vec_data_t   b;
    vec_data_t   res;
    logic [15:0] v0;
    logic [63:0] emask;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] er;
    logic [63:0] sign_a;
    logic [63:0] sign_b;
    int          ebytes;
    int          nelem;
    int          sh;
    int          i;
    int          k;
    logic        active;
    a = model_regs[vs1];
    b = model_regs[vs2];
    res = model_regs[vd];
    v0 = model_regs[0][15:0];
    ebytes = 1 << int'(sew);
    nelem = `VEC_DATA_BYTES / ebytes;
    sh = 64 - 8 * ebytes;
    emask = {64{1'b1}} >> sh;
    for (i = 0; i < nelem; i++) begin
        active = (i >= vstart) && (i < vl) && (!vm || v0[i]);
        ea = (a >> (8 * ebytes * i)) & emask;
        eb = (b >> (8 * ebytes * i)) & emask;
        // Top-aligned copies compare as signed element values
        sign_a = ea << sh;
        sign_b = eb << sh;
        if (active) begin
            if (op == OP_ADD || op == OP_SUB) begin
                er = (op == OP_ADD) ? eb + ea : eb - ea;
                for (k = 0; k < ebytes; k++) begin
                    res[8 * (ebytes * i + k) +: 8] = er[8 * k +: 8];
                end
            end else if (op == OP_MSEQ) begin
                res[i] = (ea == eb);
            end else begin
                res[i] = ($signed(sign_b) < $signed(sign_a));
            end
        end
    end
    model_regs[vd] = res;
endtask

task automatic load_reg(input int r, input vec_data_t d);
    int waited;
    next_drive_slot();
    load_valid = 1'b1;
    load_addr = vec_reg_addr_t'(r);
    load_data = d;
    #1;
    waited = 0;
    while (!load_ready && waited < TIMEOUT_CYCLES) begin
        next_drive_slot();
        #1;
        waited++;
    end
    if (!load_ready) abort_on_timeout("load_ready");
    next_drive_slot();
    load_valid = 1'b0;
    model_regs[r] = d;
endtask

// Hold is the number of cycles resp_ready stays low while a load is attempted
task automatic run_cmd(input vec_op_e op, input int vd, input int vs1, input int vs2,
                       input vec_sew_e sew, input int vl, input int vstart, input logic vm,
                       input int hold);
    int waited;
    int cycles;
    int bad_addr;
    int k;
    next_drive_slot();
    cmd_op = op;
    cmd_vd = vec_reg_addr_t'(vd);
    cmd_vs1 = vec_reg_addr_t'(vs1);
    cmd_vs2 = vec_reg_addr_t'(vs2);
    cmd_sew = sew;
    cmd_vl = vec_len_t'(vl);
    cmd_vstart = vec_len_t'(vstart);
    cmd_vm = vm;
    cmd_valid = 1'b1;
    resp_ready = (hold == 0);
    #1;
    waited = 0;
    while (!cmd_ready && waited < TIMEOUT_CYCLES) begin
        next_drive_slot();
        #1;
        waited++;
    end
    if (!cmd_ready) abort_on_timeout("cmd_ready");
    // Command transfers on the coming edge
    next_drive_slot();
    cmd_valid = 1'b0;
    predict_cmd(op, vd, vs1, vs2, sew, vl, vstart, vm);
    bad_addr = (vd + 1) % `VEC_NUM_REGS;
    if (hold > 0) begin
        load_valid = 1'b1;
        load_addr = vec_reg_addr_t'(bad_addr);
        load_data = ~model_regs[bad_addr];
    end
    #1;
    cycles = 0;
    while (!resp_valid && cycles < TIMEOUT_CYCLES) begin
        next_drive_slot();
        #1;
        cycles++;
    end
    if (!resp_valid) abort_on_timeout("resp_valid");
    num_checks++;
    if (cycles != 3) begin
        num_errors++;
        $display("FAILED at time %0t: resp_valid rose %0d cycles after accept, expected 3",
                 $time, cycles);
    end
    for (k = 0; k < hold; k++) begin
        num_checks++;
        if (!resp_valid || cmd_ready || load_ready) begin
            num_errors++;
            $display("FAILED at time %0t: under back-pressure resp_valid %b cmd_ready %b load_ready %b",
                     $time, resp_valid, cmd_ready, load_ready);
        end
        next_drive_slot();
        #1;
    end
    if (hold > 0) begin
        next_drive_slot();
        resp_ready = 1'b1;
        load_valid = 1'b0;
    end
    next_drive_slot();
    #1;
    num_checks++;
    if (resp_valid) begin
        num_errors++;
        $display("FAILED at time %0t: response did not retire after the handshake", $time);
    end
endtask

task automatic check_reg(input int r);
    next_drive_slot();
    rd_addr = vec_reg_addr_t'(r);
    #1;
    num_checks++;
    if (rd_data !== model_regs[r]) begin
        num_errors++;
        $display("FAILED at time %0t: v%0d is %h, expected %h", $time, r, rd_data,
                 model_regs[r]);
    end
endtask

task automatic check_all_regs();
    int r;
    for (r = 0; r < `VEC_NUM_REGS; r++) begin
        check_reg(r);
    end
endtask

task automatic add_bytes_full();
    load_reg(1, rand_vec());
    load_reg(2, rand_vec());
    load_reg(3, rand_vec());
    run_cmd(OP_ADD, 3, 1, 2, SEW_8, 16, 0, 1'b0, 0);
    check_all_regs();
endtask

// Borrows run through the bytes of elements 1 and 2 only
task automatic sub_words_window();
    load_reg(4, {4{32'h00000001}});
    load_reg(5, {32'h12345678, 32'h00010000, 32'h00000000, 32'h00000005});
    load_reg(6, rand_vec());
    run_cmd(OP_SUB, 6, 4, 5, SEW_32, 3, 1, 1'b0, 0);
    check_all_regs();
endtask

task automatic add_halves_masked();
    load_reg(0, {rand_word(), rand_word(), rand_word(), 32'h9c3e5ab5});
    load_reg(7, rand_vec());
    run_cmd(OP_ADD, 7, 1, 2, SEW_16, 6, 0, 1'b1, 0);
    check_all_regs();
endtask

task automatic compare_to_mask();
    vec_data_t base;
    base = rand_vec();
    load_reg(1, base);
    load_reg(2, {~base[127:64], base[63:0]});
    load_reg(3, rand_vec());
    run_cmd(OP_MSEQ, 3, 1, 2, SEW_64, 2, 0, 1'b0, 0);
    check_all_regs();
    load_reg(4, 128'h807f00ff01fe40c07f8010f00000aa55);
    load_reg(5, rand_vec());
    run_cmd(OP_MSLT, 3, 4, 5, SEW_8, 14, 2, 1'b0, 0);
    check_all_regs();
endtask

task automatic stall_response();
    int hold;
    hold = int'(rand_word() % 8) + 1;
    run_cmd(OP_SUB, 2, 3, 1, SEW_16, 8, 0, 1'b0, hold);
    check_all_regs();
    run_cmd(OP_ADD, 5, 2, 4, SEW_32, 4, 0, 1'b0, 0);
    check_all_regs();
endtask

task automatic sweep_random();
    logic [31:0] w;
    int          r;
    int          n;
    for (r = 0; r < `VEC_NUM_REGS; r++) begin
        load_reg(r, rand_vec());
    end
    for (n = 0; n < 20; n++) begin
        w = rand_word();
        run_cmd(vec_op_e'(w[1:0]), int'(w[6:4]), int'(w[9:7]), int'(w[12:10]),
                vec_sew_e'(w[3:2]), int'(rand_word() % 17), int'(rand_word() % 5),
                w[13], 0);
        check_all_regs();
    end
endtask

initial begin
    clk = 1'b0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = OP_ADD;
    cmd_vd = '0;
    cmd_vs1 = '0;
    cmd_vs2 = '0;
    cmd_sew = SEW_8;
    cmd_vl = '0;
    cmd_vstart = '0;
    cmd_vm = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    resp_ready = 1'b0;
    rd_addr = '0;
    rng_state = 32'hb061d3fa;
    num_checks = 0;
    num_errors = 0;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
        model_regs[r] = '0;
    end
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    check_all_regs();
    add_bytes_full();
    sub_words_window();
    add_halves_masked();
    compare_to_mask();
    stall_response();
    sweep_random();
    $display("Checks: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/vec_pkg.sv
verilog/vec_op_if.sv
verilog/vec_elem_decode.sv
verilog/vec_regfile.sv
verilog/vec_lane_alu.sv
verilog/vec_issue_ctrl.sv
verilog/vec_unit_top.sv
tb/vec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vec_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/vec_pkg.sv
      - verilog/vec_op_if.sv
      - verilog/vec_elem_decode.sv
      - verilog/vec_regfile.sv
      - verilog/vec_lane_alu.sv
      - verilog/vec_issue_ctrl.sv
      - verilog/vec_unit_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/vec_unit_tb.sv
